/* source/cpu_pkg.sv */
package cpu_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int REG_AW = 5;

    // Instruction field positions
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 26;
    localparam int RS_HI     = 25;
    localparam int RS_LO     = 21;
    localparam int RT_HI     = 20;
    localparam int RT_LO     = 16;
    localparam int RD_HI     = 15;
    localparam int RD_LO     = 11;
    localparam int FUNCT_HI  = 5;
    localparam int FUNCT_LO  = 0;
    localparam int IMM_HI    = 15;
    localparam int IMM_LO    = 0;
    localparam int TARGET_HI = 25;
    localparam int TARGET_LO = 0;

    // ==============================
    // Opcode and funct codes
    // ==============================
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_J     = 6'h02;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

endpackage

/* source/fetch_stage.sv */
module fetch_stage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [cpu_pkg::DATA_W-1:0]    prog_data,
    input  logic                          stall,
    input  logic                          redirect,
    input  logic [cpu_pkg::ADDR_W-1:0]    redirect_pc,
    output logic                          if_id_valid,
    output logic [cpu_pkg::DATA_W-1:0]    if_id_inst,
    output logic [cpu_pkg::ADDR_W-1:0]    if_id_pc4,
    output logic [cpu_pkg::ADDR_W-1:0]    pc,
    output logic [cpu_pkg::DATA_W-1:0]    inst
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam logic [cpu_pkg::ADDR_W-1:0] PC_STEP = 4;

    logic [cpu_pkg::DATA_W-1:0] imem [IMEM_DEPTH];
    logic [cpu_pkg::ADDR_W-1:0] pc4;

    // Program load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign inst = imem[pc[IMEM_AW+1:2]];
    assign pc4  = pc + PC_STEP;

    // Next PC, redirect first, then stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc4;
        end
    end

    // ==============================
    // IF/ID register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id_valid <= 1'b0;
        end else if (!run || redirect) begin
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            if_id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_inst <= inst;
            if_id_pc4  <= pc4;
        end
    end

    // Loading only while the core is halted
    a_load_halted: assert property (@(posedge clk) disable iff (!rst_n) run |-> !prog_we)
        else $error("prog_we high while run is high");

endmodule

/* source/reg_file.sv */
module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpu_pkg::REG_AW-1:0] raddr1,
    input  logic [cpu_pkg::REG_AW-1:0] raddr2,
    input  logic                       wb_en,
    input  logic [cpu_pkg::REG_AW-1:0] wb_addr,
    input  logic [cpu_pkg::DATA_W-1:0] wb_data,
    output logic [cpu_pkg::DATA_W-1:0] rdata1,
    output logic [cpu_pkg::DATA_W-1:0] rdata2
);

    logic [cpu_pkg::DATA_W-1:0] regs [32];

    // Register 0 is never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Same-cycle write passes through to the read
    function automatic logic [cpu_pkg::DATA_W-1:0] read_port(
        input logic [cpu_pkg::REG_AW-1:0] ra
    );
        if (ra == '0) begin
            return '0;
        end
        if (wb_en && wb_addr == ra) begin
            return wb_data;
        end
        return regs[ra];
    endfunction

    assign rdata1 = read_port(raddr1);
    assign rdata2 = read_port(raddr2);

endmodule

/* source/decode_stage.sv */
module decode_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       if_id_valid,
    input  logic [cpu_pkg::DATA_W-1:0] if_id_inst,
    input  logic [cpu_pkg::ADDR_W-1:0] if_id_pc4,
    input  logic [cpu_pkg::DATA_W-1:0] rdata1,
    input  logic [cpu_pkg::DATA_W-1:0] rdata2,
    input  logic                       redirect,
    output logic [cpu_pkg::REG_AW-1:0] raddr1,
    output logic [cpu_pkg::REG_AW-1:0] raddr2,
    output logic                       stall,
    output logic                       id_ex_valid,
    output cpu_pkg::alu_op_e           id_ex_alu_op,
    output logic                       id_ex_alu_src,
    output logic                       id_ex_reg_write,
    output logic                       id_ex_mem_read,
    output logic                       id_ex_mem_write,
    output logic                       id_ex_branch,
    output logic                       id_ex_jump,
    output logic [cpu_pkg::REG_AW-1:0] id_ex_rs,
    output logic [cpu_pkg::REG_AW-1:0] id_ex_rt,
    output logic [cpu_pkg::REG_AW-1:0] id_ex_dest,
    output logic [cpu_pkg::DATA_W-1:0] id_ex_a,
    output logic [cpu_pkg::DATA_W-1:0] id_ex_b,
    output logic [cpu_pkg::DATA_W-1:0] id_ex_imm,
    output logic [cpu_pkg::ADDR_W-1:0] id_ex_pc4,
    output logic [cpu_pkg::ADDR_W-1:0] id_ex_jump_pc
);

    logic [5:0]                 opcode;
    logic [5:0]                 funct;
    logic [cpu_pkg::REG_AW-1:0] rs;
    logic [cpu_pkg::REG_AW-1:0] rt;
    logic [cpu_pkg::REG_AW-1:0] rd;
    logic [cpu_pkg::DATA_W-1:0] imm;
    cpu_pkg::alu_op_e           alu_op;
    logic alu_src, reg_write, mem_read, mem_write, branch, jump, uses_rt;

    assign opcode = if_id_inst[cpu_pkg::OPCODE_HI:cpu_pkg::OPCODE_LO];
    assign funct  = if_id_inst[cpu_pkg::FUNCT_HI:cpu_pkg::FUNCT_LO];
    assign rs     = if_id_inst[cpu_pkg::RS_HI:cpu_pkg::RS_LO];
    assign rt     = if_id_inst[cpu_pkg::RT_HI:cpu_pkg::RT_LO];
    assign rd     = if_id_inst[cpu_pkg::RD_HI:cpu_pkg::RD_LO];
    assign imm    = {{16{if_id_inst[cpu_pkg::IMM_HI]}},
                     if_id_inst[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO]};
    assign raddr1 = rs;
    assign raddr2 = rt;

    // ==============================
    // Control decode
    // ==============================
    always_comb begin
        alu_op    = cpu_pkg::ALU_ADD;
        alu_src   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        case (opcode)
            cpu_pkg::OP_RTYPE: begin
                reg_write = 1'b1;
                case (funct)
                    cpu_pkg::FN_ADD: alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUB: alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:  alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_SLT: alu_op = cpu_pkg::ALU_SLT;
                    default:         reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDI: {alu_src, reg_write} = 2'b11;
            cpu_pkg::OP_LW:   {alu_src, reg_write, mem_read} = 3'b111;
            cpu_pkg::OP_SW:   {alu_src, mem_write} = 2'b11;
            cpu_pkg::OP_BEQ:  branch = 1'b1;
            cpu_pkg::OP_J:    jump = 1'b1;
            default:          ;
        endcase
    end

    assign uses_rt = (opcode == cpu_pkg::OP_RTYPE) || mem_write || branch;

    // Load-use hazard against the entry in ID/EX
    assign stall = if_id_valid && id_ex_valid && id_ex_mem_read && id_ex_dest != '0
                   && ((!jump && id_ex_dest == rs) || (uses_rt && id_ex_dest == rt));

    // ==============================
    // ID/EX register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_valid     <= 1'b0;
            id_ex_alu_op    <= cpu_pkg::ALU_ADD;
            id_ex_alu_src   <= 1'b0;
            id_ex_reg_write <= 1'b0;
            id_ex_mem_read  <= 1'b0;
            id_ex_mem_write <= 1'b0;
            id_ex_branch    <= 1'b0;
            id_ex_jump      <= 1'b0;
        end else begin
            id_ex_valid     <= if_id_valid && !stall && !redirect;
            id_ex_alu_op    <= alu_op;
            id_ex_alu_src   <= alu_src;
            id_ex_reg_write <= reg_write;
            id_ex_mem_read  <= mem_read;
            id_ex_mem_write <= mem_write;
            id_ex_branch    <= branch;
            id_ex_jump      <= jump;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_rs      <= rs;
        id_ex_rt      <= rt;
        id_ex_dest    <= (opcode == cpu_pkg::OP_RTYPE) ? rd : rt;
        id_ex_a       <= rdata1;
        id_ex_b       <= rdata2;
        id_ex_imm     <= imm;
        id_ex_pc4     <= if_id_pc4;
        id_ex_jump_pc <= {if_id_pc4[31:28], if_id_inst[cpu_pkg::TARGET_HI:cpu_pkg::TARGET_LO],
                          2'b00};
    end

    // A load in ID/EX never redirects the fetch
    a_stall_no_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !redirect)
        else $error("stall and redirect in the same cycle");

endmodule

/* source/execute_stage.sv */
module execute_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       id_ex_valid,
    input  cpu_pkg::alu_op_e           id_ex_alu_op,
    input  logic                       id_ex_alu_src,
    input  logic                       id_ex_reg_write,
    input  logic                       id_ex_mem_read,
    input  logic                       id_ex_mem_write,
    input  logic                       id_ex_branch,
    input  logic                       id_ex_jump,
    input  logic [cpu_pkg::REG_AW-1:0] id_ex_rs,
    input  logic [cpu_pkg::REG_AW-1:0] id_ex_rt,
    input  logic [cpu_pkg::REG_AW-1:0] id_ex_dest,
    input  logic [cpu_pkg::DATA_W-1:0] id_ex_a,
    input  logic [cpu_pkg::DATA_W-1:0] id_ex_b,
    input  logic [cpu_pkg::DATA_W-1:0] id_ex_imm,
    input  logic [cpu_pkg::ADDR_W-1:0] id_ex_pc4,
    input  logic [cpu_pkg::ADDR_W-1:0] id_ex_jump_pc,
    input  logic                       mem_fwd_en,
    input  logic [cpu_pkg::REG_AW-1:0] mem_fwd_addr,
    input  logic [cpu_pkg::DATA_W-1:0] mem_fwd_data,
    input  logic                       wb_en,
    input  logic [cpu_pkg::REG_AW-1:0] wb_addr,
    input  logic [cpu_pkg::DATA_W-1:0] wb_data,
    output logic                       redirect,
    output logic [cpu_pkg::ADDR_W-1:0] redirect_pc,
    output logic                       ex_mem_valid,
    output logic                       ex_mem_reg_write,
    output logic                       ex_mem_mem_read,
    output logic                       ex_mem_mem_write,
    output logic [cpu_pkg::REG_AW-1:0] ex_mem_dest,
    output logic [cpu_pkg::DATA_W-1:0] ex_mem_result,
    output logic [cpu_pkg::DATA_W-1:0] ex_mem_store_data
);

    logic [cpu_pkg::DATA_W-1:0] op_a, fwd_b, op_b, result;

    // EX/MEM wins over MEM/WB and register 0 is never forwarded
    function automatic logic [cpu_pkg::DATA_W-1:0] forward(
        input logic [cpu_pkg::REG_AW-1:0] src,
        input logic [cpu_pkg::DATA_W-1:0] reg_val
    );
        if (src == '0) begin
            return reg_val;
        end
        if (mem_fwd_en && mem_fwd_addr == src) begin
            return mem_fwd_data;
        end
        if (wb_en && wb_addr == src) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    assign op_a  = forward(id_ex_rs, id_ex_a);
    assign fwd_b = forward(id_ex_rt, id_ex_b);
    assign op_b  = id_ex_alu_src ? id_ex_imm : fwd_b;

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (id_ex_alu_op)
            cpu_pkg::ALU_SUB: result = op_a - op_b;
            cpu_pkg::ALU_AND: result = op_a & op_b;
            cpu_pkg::ALU_OR:  result = op_a | op_b;
            cpu_pkg::ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
            default:          result = op_a + op_b;
        endcase
    end

    // beq and j resolve here
    assign redirect    = id_ex_valid && (id_ex_jump || (id_ex_branch && op_a == fwd_b));
    assign redirect_pc = id_ex_jump ? id_ex_jump_pc : id_ex_pc4 + {id_ex_imm[29:0], 2'b00};

    // ==============================
    // EX/MEM register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_valid     <= 1'b0;
            ex_mem_reg_write <= 1'b0;
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
        end else begin
            ex_mem_valid     <= id_ex_valid;
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_dest       <= id_ex_dest;
        ex_mem_result     <= result;
        ex_mem_store_data <= fwd_b;
    end

    // Both younger instructions are gone after a redirect
    a_redirect_flush: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !id_ex_valid ##1 !id_ex_valid)
        else $error("instruction behind a redirect was not flushed");

endmodule

/* source/memory_stage.sv */
module memory_stage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ex_mem_valid,
    input  logic                       ex_mem_reg_write,
    input  logic                       ex_mem_mem_read,
    input  logic                       ex_mem_mem_write,
    input  logic [cpu_pkg::REG_AW-1:0] ex_mem_dest,
    input  logic [cpu_pkg::DATA_W-1:0] ex_mem_result,
    input  logic [cpu_pkg::DATA_W-1:0] ex_mem_store_data,
    output logic                       mem_fwd_en,
    output logic [cpu_pkg::REG_AW-1:0] mem_fwd_addr,
    output logic [cpu_pkg::DATA_W-1:0] mem_fwd_data,
    output logic                       wb_en,
    output logic [cpu_pkg::REG_AW-1:0] wb_addr,
    output logic [cpu_pkg::DATA_W-1:0] wb_data
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [cpu_pkg::DATA_W-1:0] dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0]         word_idx;

    assign word_idx = ex_mem_result[DMEM_AW+1:2];

    // Data memory, word access only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_valid && ex_mem_mem_write) begin
            dmem[word_idx] <= ex_mem_store_data;
        end
    end

    // A load result is not ready here, so it is not forwarded
    assign mem_fwd_en   = ex_mem_valid && ex_mem_reg_write && !ex_mem_mem_read;
    assign mem_fwd_addr = ex_mem_dest;
    assign mem_fwd_data = ex_mem_result;

    // ==============================
    // MEM/WB register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= ex_mem_valid && ex_mem_reg_write && ex_mem_dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= ex_mem_dest;
        wb_data <= ex_mem_mem_read ? dmem[word_idx] : ex_mem_result;
    end

    a_dmem_range: assert property (@(posedge clk) disable iff (!rst_n)
        ex_mem_valid && (ex_mem_mem_read || ex_mem_mem_write)
            |-> (ex_mem_result >> 2) < DMEM_DEPTH)
        else $error("data access out of range: %h", ex_mem_result);

endmodule

/* source/pipelined_cpu.sv */
module pipelined_cpu #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [cpu_pkg::DATA_W-1:0]    prog_data,
    output logic [cpu_pkg::ADDR_W-1:0]    pc,
    output logic [cpu_pkg::DATA_W-1:0]    inst,
    output logic                          wb_en,
    output logic [cpu_pkg::REG_AW-1:0]    wb_addr,
    output logic [cpu_pkg::DATA_W-1:0]    wb_data
);

    // Hazard control
    logic                       stall, redirect;
    logic [cpu_pkg::ADDR_W-1:0] redirect_pc;

    // IF/ID and register file
    logic                       if_id_valid;
    logic [cpu_pkg::DATA_W-1:0] if_id_inst, rdata1, rdata2;
    logic [cpu_pkg::ADDR_W-1:0] if_id_pc4;
    logic [cpu_pkg::REG_AW-1:0] raddr1, raddr2;

    // ID/EX
    cpu_pkg::alu_op_e           id_ex_alu_op;
    logic id_ex_valid, id_ex_alu_src, id_ex_reg_write, id_ex_mem_read;
    logic id_ex_mem_write, id_ex_branch, id_ex_jump;
    logic [cpu_pkg::REG_AW-1:0] id_ex_rs, id_ex_rt, id_ex_dest;
    logic [cpu_pkg::DATA_W-1:0] id_ex_a, id_ex_b, id_ex_imm;
    logic [cpu_pkg::ADDR_W-1:0] id_ex_pc4, id_ex_jump_pc;

    // EX/MEM and forwarding
    logic ex_mem_valid, ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write;
    logic [cpu_pkg::REG_AW-1:0] ex_mem_dest, mem_fwd_addr;
    logic [cpu_pkg::DATA_W-1:0] ex_mem_result, ex_mem_store_data, mem_fwd_data;
    logic                       mem_fwd_en;

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data,
        .stall, .redirect, .redirect_pc,
        .if_id_valid, .if_id_inst, .if_id_pc4, .pc, .inst
    );

    reg_file u_reg_file (
        .clk, .rst_n, .raddr1, .raddr2,
        .wb_en, .wb_addr, .wb_data, .rdata1, .rdata2
    );

    decode_stage u_decode (
        .clk, .rst_n, .if_id_valid, .if_id_inst, .if_id_pc4,
        .rdata1, .rdata2, .redirect, .raddr1, .raddr2, .stall,
        .id_ex_valid, .id_ex_alu_op, .id_ex_alu_src, .id_ex_reg_write,
        .id_ex_mem_read, .id_ex_mem_write, .id_ex_branch, .id_ex_jump,
        .id_ex_rs, .id_ex_rt, .id_ex_dest, .id_ex_a, .id_ex_b,
        .id_ex_imm, .id_ex_pc4, .id_ex_jump_pc
    );

    execute_stage u_execute (
        .clk, .rst_n,
        .id_ex_valid, .id_ex_alu_op, .id_ex_alu_src, .id_ex_reg_write,
        .id_ex_mem_read, .id_ex_mem_write, .id_ex_branch, .id_ex_jump,
        .id_ex_rs, .id_ex_rt, .id_ex_dest, .id_ex_a, .id_ex_b,
        .id_ex_imm, .id_ex_pc4, .id_ex_jump_pc,
        .mem_fwd_en, .mem_fwd_addr, .mem_fwd_data, .wb_en, .wb_addr, .wb_data,
        .redirect, .redirect_pc,
        .ex_mem_valid, .ex_mem_reg_write, .ex_mem_mem_read, .ex_mem_mem_write,
        .ex_mem_dest, .ex_mem_result, .ex_mem_store_data
    );

    memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
        .clk, .rst_n,
        .ex_mem_valid, .ex_mem_reg_write, .ex_mem_mem_read, .ex_mem_mem_write,
        .ex_mem_dest, .ex_mem_result, .ex_mem_store_data,
        .mem_fwd_en, .mem_fwd_addr, .mem_fwd_data, .wb_en, .wb_addr, .wb_data
    );

endmodule

/* verif/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held over RESET_CYCLES rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* verif/cpu_tb.sv */
module cpu_tb;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
    localparam int MAX_STEPS  = 500;
    localparam int TIMEOUT    = 1000;

    logic                       clk;
    logic                       rst_n;
    logic                       run;
    logic                       prog_we;
    logic [IMEM_AW-1:0]         prog_addr;
    logic [cpu_pkg::DATA_W-1:0] prog_data;
    logic [cpu_pkg::ADDR_W-1:0] pc;
    logic [cpu_pkg::DATA_W-1:0] inst;
    logic                       wb_en;
    logic [cpu_pkg::REG_AW-1:0] wb_addr;
    logic [cpu_pkg::DATA_W-1:0] wb_data;

    logic [cpu_pkg::DATA_W-1:0] prog [IMEM_DEPTH];
    logic [cpu_pkg::DATA_W-1:0] model_regs [32];
    logic [cpu_pkg::DATA_W-1:0] model_mem [DMEM_DEPTH];
    logic [cpu_pkg::REG_AW-1:0] exp_addr [$];
    logic [cpu_pkg::DATA_W-1:0] exp_data [$];
    logic [cpu_pkg::ADDR_W-1:0] halt_pc;
    logic [31:0]                rng_state;
    int                         prog_len;
    int                         exp_count;
    int                         err_count;
    int                         write_count;

    tb_clock #(.PERIOD(10), .RESET_CYCLES(5)) u_clock (.clk, .rst_n);

    pipelined_cpu #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) dut (
        .clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data,
        .pc, .inst, .wb_en, .wb_addr, .wb_data
    );

    // ==============================
    // Instruction encoding
    // ==============================
    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {cpu_pkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [25:0] target);
        return {cpu_pkg::OP_J, target};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [15:0] next_imm();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    task automatic add_inst(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        rng_state = 32'hf00e;
        prog_len  = 0;
        // Unused slots jump to themselves
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            prog[i] = jump_word(i[25:0]);
        end
        // Dependent ALU chain
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd1, 5'd0, next_imm()));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd2, 5'd0, next_imm()));
        add_inst(rtype_word(cpu_pkg::FN_ADD, 5'd3, 5'd1, 5'd2));
        add_inst(rtype_word(cpu_pkg::FN_SUB, 5'd4, 5'd3, 5'd1));
        add_inst(rtype_word(cpu_pkg::FN_AND, 5'd5, 5'd4, 5'd3));
        add_inst(rtype_word(cpu_pkg::FN_OR, 5'd6, 5'd5, 5'd2));
        add_inst(rtype_word(cpu_pkg::FN_SLT, 5'd7, 5'd4, 5'd6));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd0, 5'd1, next_imm()));
        // Store, load and load-use
        add_inst(itype_word(cpu_pkg::OP_SW, 5'd3, 5'd0, 16'd8));
        add_inst(itype_word(cpu_pkg::OP_LW, 5'd8, 5'd0, 16'd8));
        add_inst(rtype_word(cpu_pkg::FN_ADD, 5'd9, 5'd8, 5'd1));
        add_inst(itype_word(cpu_pkg::OP_LW, 5'd10, 5'd0, 16'd8));
        add_inst(itype_word(cpu_pkg::OP_SW, 5'd10, 5'd0, 16'd12));
        add_inst(itype_word(cpu_pkg::OP_LW, 5'd11, 5'd0, 16'd12));
        add_inst(rtype_word(cpu_pkg::FN_SUB, 5'd12, 5'd11, 5'd9));
        // Taken beq over two writes, then a not-taken one
        add_inst(itype_word(cpu_pkg::OP_BEQ, 5'd3, 5'd8, 16'd2));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd13, 5'd0, 16'd1));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd14, 5'd0, 16'd2));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd15, 5'd0, next_imm()));
        add_inst(itype_word(cpu_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd16, 5'd1, 16'd3));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd17, 5'd2, 16'd5));
        // Jump over two writes, then halt
        add_inst(jump_word(26'd25));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd18, 5'd0, 16'd7));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd19, 5'd0, 16'd8));
        add_inst(itype_word(cpu_pkg::OP_ADDI, 5'd20, 5'd15, next_imm()));
        add_inst(jump_word(26'd26));
    endtask

    // ==============================
    // Reference model
    // ==============================
    task automatic model_program();
        logic [31:0] mpc, w, a, b, imm, ea, res;
        logic [4:0]  dst;
        logic        wr;
        logic        halted;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        mpc     = '0;
        halt_pc = '0;
        halted  = 1'b0;
        steps   = 0;
        while (!halted && steps < MAX_STEPS) begin
            w   = prog[mpc[IMEM_AW+1:2]];
            a   = model_regs[w[25:21]];
            b   = model_regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            ea  = a + imm;
            dst = w[20:16];
            wr  = 1'b0;
            res = '0;
            steps++;
            if (w[31:26] == cpu_pkg::OP_J && w[25:0] == mpc[27:2]) begin
                halted  = 1'b1;
                halt_pc = mpc;
            end else begin
                mpc = mpc + 32'd4;
                case (w[31:26])
                    cpu_pkg::OP_RTYPE: begin
                        wr  = 1'b1;
                        dst = w[15:11];
                        case (w[5:0])
                            cpu_pkg::FN_ADD: res = a + b;
                            cpu_pkg::FN_SUB: res = a - b;
                            cpu_pkg::FN_AND: res = a & b;
                            cpu_pkg::FN_OR:  res = a | b;
                            cpu_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            default:         wr = 1'b0;
                        endcase
                    end
                    cpu_pkg::OP_ADDI: begin
                        wr  = 1'b1;
                        res = ea;
                    end
                    cpu_pkg::OP_LW: begin
                        wr  = 1'b1;
                        res = model_mem[ea[DMEM_AW+1:2]];
                    end
                    cpu_pkg::OP_SW:  model_mem[ea[DMEM_AW+1:2]] = b;
                    cpu_pkg::OP_BEQ: if (a == b) mpc = mpc + {imm[29:0], 2'b00};
                    cpu_pkg::OP_J:   mpc = {mpc[31:28], w[25:0], 2'b00};
                    default:         ;
                endcase
                if (wr && dst != 5'd0) begin
                    model_regs[dst] = res;
                    exp_addr.push_back(dst);
                    exp_data.push_back(res);
                end
            end
        end
        if (!halted) begin
            err_count++;
            $display("reference model did not reach the halt loop");
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = i[IMEM_AW-1:0];
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    // ==============================
    // Write-back checking
    // ==============================
    always @(posedge clk) begin
        if (!rst_n || !run) begin
            a_idle_quiet: assert (!wb_en) else begin
                err_count++;
                $display("ERR %0t wb_en expected 0 got %b", $time, wb_en);
            end
            a_pc_idle: assert (pc == '0) else begin
                err_count++;
                $display("ERR %0t pc expected 0 got %h", $time, pc);
            end
        end else begin
            a_inst_fetched: assert (inst == prog[pc[IMEM_AW+1:2]]) else begin
                err_count++;
                $display("ERR %0t inst expected %h got %h", $time,
                         prog[pc[IMEM_AW+1:2]], inst);
            end
        end
        if (rst_n && run && wb_en) begin
            write_count++;
            a_no_r0: assert (wb_addr != '0) else begin
                err_count++;
                $display("ERR %0t wb_addr expected nonzero got %0d", $time, wb_addr);
            end
            a_write_expected: assert (exp_addr.size() != 0) else begin
                err_count++;
                $display("register write to r%0d after the last expected one", wb_addr);
            end
            if (exp_addr.size() != 0) begin
                a_wb_addr: assert (wb_addr == exp_addr[0]) else begin
                    err_count++;
                    $display("ERR %0t wb_addr expected %0d got %0d", $time, exp_addr[0], wb_addr);
                end
                a_wb_data: assert (wb_data == exp_data[0]) else begin
                    err_count++;
                    $display("ERR %0t wb_data expected %h got %h", $time, exp_data[0], wb_data);
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        int wait_cycles;
        run         = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        err_count   = 0;
        write_count = 0;
        build_program();
        model_program();
        exp_count = exp_addr.size();

        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            err_count++;
            $display("reset was never released");
        end

        load_program();
        @(negedge clk);
        run = 1'b1;

        wait_cycles = 0;
        while (exp_addr.size() != 0 && wait_cycles < TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (exp_addr.size() != 0) begin
            err_count++;
            $display("timed out with %0d register writes still missing", exp_addr.size());
        end

        // The halt loop must stay silent
        repeat (20) @(negedge clk);
        // Fetch circles over the halt jump and its two flushed successors
        a_pc_halt: assert (pc - halt_pc <= 32'd8) else begin
            err_count++;
            $display("ERR %0t pc expected %h to %h got %h", $time,
                     halt_pc, halt_pc + 32'd8, pc);
        end
        $display("errors: %0d, writes seen: %0d, writes expected: %0d",
                 err_count, write_count, exp_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
source/cpu_pkg.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/pipelined_cpu.sv
verif/tb_clock.sv
verif/cpu_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = cpu_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
